// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_dbus_top
FLIST     = flist.f
BUILD     = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== flist.f ====
hdl/dbus_pkg.sv
hdl/tcm.sv
hdl/timer_regs.sv
hdl/axil_bus_ctrl.sv
hdl/dbus_top.sv
testbench/tb_dbus_top.sv

// ==== hdl/axil_bus_ctrl.sv ====
`timescale 1ns/1ps

module axil_bus_ctrl
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,

    input  dbus_pkg::addr_t         i_awaddr,
    input  wire                     i_awvalid,
    output logic                    o_awready,
    input  dbus_pkg::data_t         i_wdata,
    input  dbus_pkg::strb_t         i_wstrb,
    input  wire                     i_wvalid,
    output logic                    o_wready,
    output logic                    o_bvalid,
    output dbus_pkg::resp_t         o_bresp,
    input  wire                     i_bready,
    input  dbus_pkg::addr_t         i_araddr,
    input  wire                     i_arvalid,
    output logic                    o_arready,
    output logic                    o_rvalid,
    output dbus_pkg::data_t         o_rdata,
    output dbus_pkg::resp_t         o_rresp,
    input  wire                     i_rready,

    output dbus_pkg::word_addr_t    o_dev_addr,
    output dbus_pkg::strb_t         o_dev_sel,
    output logic                    o_dev_write,
    output dbus_pkg::data_t         o_dev_wdata,
    output logic                    o_tcm_cs,
    output logic                    o_tmr_cs,
    input  wire                     i_tcm_ack,
    input  dbus_pkg::data_t         i_tcm_rdata,
    input  wire                     i_tmr_ack,
    input  dbus_pkg::data_t         i_tmr_rdata
);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_COLLECT,     // one of aw/w latched
        ST_ACCESS,      // decode, raise select
        ST_WAIT_ACK,
        ST_WRESP,
        ST_RRESP
    } state_t;

    state_t             state;
    logic               ready_en;
    logic               aw_got;
    logic               w_got;
    logic               is_write;
    dbus_pkg::addr_t    r_addr;
    dbus_pkg::data_t    r_wdata;
    dbus_pkg::strb_t    r_wstrb;
    dbus_pkg::addr_t    tmr_ofs;
    logic               hit_tcm;
    logic               hit_tmr;
    logic               aw_hs;
    logic               w_hs;
    logic               ar_hs;
    logic               dev_ack;

    assign o_awready = ready_en && (state == ST_IDLE || state == ST_COLLECT) && !aw_got;
    assign o_wready  = ready_en && (state == ST_IDLE || state == ST_COLLECT) && !w_got;
    assign o_arready = ready_en && (state == ST_IDLE)
                       && !i_awvalid && !i_wvalid;  // writes first

    assign aw_hs = i_awvalid && o_awready;
    assign w_hs  = i_wvalid && o_wready;
    assign ar_hs = i_arvalid && o_arready;

    // address decode, word aligned
    assign hit_tcm = (r_addr & ~dbus_pkg::addr_t'(dbus_pkg::TCM_BYTES - 1))
                     == dbus_pkg::TCM_BASE;
    assign tmr_ofs = (r_addr - dbus_pkg::TIMER_BASE) & ~dbus_pkg::addr_t'(3);
    assign hit_tmr = (tmr_ofs == dbus_pkg::TIMER_COUNT_OFS) ||
                     (tmr_ofs == dbus_pkg::TIMER_CMP_OFS) ||
                     (tmr_ofs == dbus_pkg::TIMER_STATUS_OFS);

    assign o_dev_addr  = r_addr[dbus_pkg::TCM_ADDR_WIDTH+1:2];  // timer words share these bits
    assign o_dev_sel   = is_write ? r_wstrb : '1;
    assign o_dev_write = is_write;
    assign o_dev_wdata = r_wdata;

    assign dev_ack = i_tcm_ack || i_tmr_ack;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state    <= ST_IDLE;
            ready_en <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            is_write <= 1'b0;
            o_tcm_cs <= 1'b0;
            o_tmr_cs <= 1'b0;
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
            o_bresp  <= dbus_pkg::RESP_OKAY;
            o_rresp  <= dbus_pkg::RESP_OKAY;
        end
        else
        begin
            ready_en <= 1'b1;  // readies stay low until first edge out of reset
            o_tcm_cs <= 1'b0;  // one-cycle pulses
            o_tmr_cs <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (aw_hs)
                        aw_got <= 1'b1;
                    if (w_hs)
                        w_got <= 1'b1;
                    if (aw_hs && w_hs)
                    begin
                        is_write <= 1'b1;
                        state    <= ST_ACCESS;
                    end
                    else if (aw_hs || w_hs)
                        state <= ST_COLLECT;
                    else if (ar_hs)
                    begin
                        is_write <= 1'b0;
                        state    <= ST_ACCESS;
                    end
                end
                ST_COLLECT:
                begin
                    if (aw_hs)
                        aw_got <= 1'b1;
                    if (w_hs)
                        w_got <= 1'b1;
                    if ((aw_got || aw_hs) && (w_got || w_hs))
                    begin
                        is_write <= 1'b1;
                        state    <= ST_ACCESS;
                    end
                end
                ST_ACCESS:
                begin
                    if (hit_tcm || hit_tmr)
                    begin
                        o_tcm_cs <= hit_tcm;
                        o_tmr_cs <= hit_tmr;
                        state    <= ST_WAIT_ACK;
                    end
                    else if (is_write)
                    begin
                        o_bvalid <= 1'b1;
                        o_bresp  <= dbus_pkg::RESP_DECERR;
                        state    <= ST_WRESP;
                    end
                    else
                    begin
                        o_rvalid <= 1'b1;
                        o_rresp  <= dbus_pkg::RESP_DECERR;
                        state    <= ST_RRESP;
                    end
                end
                ST_WAIT_ACK:
                begin
                    if (dev_ack && is_write)
                    begin
                        o_bvalid <= 1'b1;
                        o_bresp  <= dbus_pkg::RESP_OKAY;
                        state    <= ST_WRESP;
                    end
                    else if (dev_ack)
                    begin
                        o_rvalid <= 1'b1;
                        o_rresp  <= dbus_pkg::RESP_OKAY;
                        state    <= ST_RRESP;
                    end
                end
                ST_WRESP:
                begin
                    if (i_bready)
                    begin
                        o_bvalid <= 1'b0;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                ST_RRESP:
                begin
                    if (i_rready)
                    begin
                        o_rvalid <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (aw_hs)
            r_addr <= i_awaddr;
        else if (ar_hs)
            r_addr <= i_araddr;

        if (w_hs)
        begin
            r_wdata <= i_wdata;
            r_wstrb <= i_wstrb;
        end

        if (state == ST_ACCESS && !hit_tcm && !hit_tmr)
            o_rdata <= '0;  // decerr reads return zero
        else if (state == ST_WAIT_ACK && dev_ack && !is_write)
            o_rdata <= i_tcm_ack ? i_tcm_rdata : i_tmr_rdata;
    end

endmodule

// ==== hdl/dbus_pkg.sv ====
package dbus_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;
    localparam int TCM_ADDR_WIDTH = 8;                      // 256 words

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;
    typedef logic [TCM_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [1:0]                resp_t;

    // address map
    localparam addr_t TCM_BASE  = 32'h0000_0000;
    localparam int    TCM_BYTES = (2 ** TCM_ADDR_WIDTH) * STRB_WIDTH;

    localparam addr_t TIMER_BASE       = 32'h0000_1000;
    localparam addr_t TIMER_COUNT_OFS  = 32'h0000_0000;   // read only
    localparam addr_t TIMER_CMP_OFS    = 32'h0000_0004;
    localparam addr_t TIMER_STATUS_OFS = 32'h0000_0008;   // bit 0, write 1 to clear

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

// ==== hdl/dbus_top.sv ====
`timescale 1ns/1ps

module dbus_top
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  dbus_pkg::addr_t     i_awaddr,
    input  wire                 i_awvalid,
    output logic                o_awready,
    input  dbus_pkg::data_t     i_wdata,
    input  dbus_pkg::strb_t     i_wstrb,
    input  wire                 i_wvalid,
    output logic                o_wready,
    output logic                o_bvalid,
    output dbus_pkg::resp_t     o_bresp,
    input  wire                 i_bready,
    input  dbus_pkg::addr_t     i_araddr,
    input  wire                 i_arvalid,
    output logic                o_arready,
    output logic                o_rvalid,
    output dbus_pkg::data_t     o_rdata,
    output dbus_pkg::resp_t     o_rresp,
    input  wire                 i_rready,

    output logic                o_irq
);

    dbus_pkg::word_addr_t   dev_addr;
    dbus_pkg::strb_t        dev_sel;
    logic                   dev_write;
    dbus_pkg::data_t        dev_wdata;
    logic                   tcm_cs;
    logic                   tmr_cs;
    logic                   tcm_ack;
    logic                   tmr_ack;
    dbus_pkg::data_t        tcm_rdata;
    dbus_pkg::data_t        tmr_rdata;

    axil_bus_ctrl u_ctrl
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_awaddr    (i_awaddr),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_wdata     (i_wdata),
        .i_wstrb     (i_wstrb),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_bvalid    (o_bvalid),
        .o_bresp     (o_bresp),
        .i_bready    (i_bready),
        .i_araddr    (i_araddr),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_rvalid    (o_rvalid),
        .o_rdata     (o_rdata),
        .o_rresp     (o_rresp),
        .i_rready    (i_rready),
        .o_dev_addr  (dev_addr),
        .o_dev_sel   (dev_sel),
        .o_dev_write (dev_write),
        .o_dev_wdata (dev_wdata),
        .o_tcm_cs    (tcm_cs),
        .o_tmr_cs    (tmr_cs),
        .i_tcm_ack   (tcm_ack),
        .i_tcm_rdata (tcm_rdata),
        .i_tmr_ack   (tmr_ack),
        .i_tmr_rdata (tmr_rdata)
    );

    tcm u_tcm
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cs    (tcm_cs),
        .i_addr  (dev_addr),
        .i_sel   (dev_sel),
        .i_write (dev_write),
        .i_wdata (dev_wdata),
        .o_ack   (tcm_ack),
        .o_rdata (tcm_rdata)
    );

    timer_regs u_timer
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cs    (tmr_cs),
        .i_addr  (dev_addr),
        .i_sel   (dev_sel),
        .i_write (dev_write),
        .i_wdata (dev_wdata),
        .o_ack   (tmr_ack),
        .o_rdata (tmr_rdata),
        .o_irq   (o_irq)
    );

endmodule

// ==== hdl/tcm.sv ====
`timescale 1ns/1ps

module tcm
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_cs,
    input  dbus_pkg::word_addr_t    i_addr,
    input  dbus_pkg::strb_t         i_sel,
    input  wire                     i_write,
    input  dbus_pkg::data_t         i_wdata,
    output logic                    o_ack,
    output dbus_pkg::data_t         o_rdata
);

    localparam int MemWords = 2 ** dbus_pkg::TCM_ADDR_WIDTH;

    dbus_pkg::data_t        r_mem [MemWords];
    dbus_pkg::word_addr_t   r_addr;
    dbus_pkg::strb_t        r_sel;
    dbus_pkg::data_t        r_wdata;
    logic                   r_write;

    // bus sampled every cycle, only used while ack is high
    always_ff @(posedge i_clk)
    begin
        r_addr  <= i_addr;
        r_sel   <= i_sel;
        r_wdata <= i_wdata;
        r_write <= i_write;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_ack <= 1'b0;
        else
            o_ack <= i_cs;
    end

    always_ff @(posedge i_clk)
    begin
        if (r_write && o_ack)
        begin
            for (int i = 0; i < dbus_pkg::STRB_WIDTH; i++)
            begin
                if (r_sel[i])
                    r_mem[r_addr][i*8 +: 8] <= r_wdata[i*8 +: 8];
            end
        end
    end

    assign o_rdata = r_mem[r_addr];  // async read at latched address

endmodule

// ==== hdl/timer_regs.sv ====
`timescale 1ns/1ps

module timer_regs
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_cs,
    input  dbus_pkg::word_addr_t    i_addr,
    input  dbus_pkg::strb_t         i_sel,
    input  wire                     i_write,
    input  dbus_pkg::data_t         i_wdata,
    output logic                    o_ack,
    output dbus_pkg::data_t         o_rdata,
    output logic                    o_irq
);

    localparam dbus_pkg::word_addr_t CountWord =
        dbus_pkg::word_addr_t'(dbus_pkg::TIMER_COUNT_OFS >> 2);
    localparam dbus_pkg::word_addr_t CmpWord =
        dbus_pkg::word_addr_t'(dbus_pkg::TIMER_CMP_OFS >> 2);
    localparam dbus_pkg::word_addr_t StatusWord =
        dbus_pkg::word_addr_t'(dbus_pkg::TIMER_STATUS_OFS >> 2);

    dbus_pkg::word_addr_t   r_addr;
    dbus_pkg::strb_t        r_sel;
    dbus_pkg::data_t        r_wdata;
    logic                   r_write;
    dbus_pkg::data_t        r_count;
    dbus_pkg::data_t        r_cmp;
    logic                   r_match;
    logic                   wr_en;

    always_ff @(posedge i_clk)
    begin
        r_addr  <= i_addr;
        r_sel   <= i_sel;
        r_wdata <= i_wdata;
        r_write <= i_write;
    end

    assign wr_en = r_write && o_ack;  // commits at end of ack cycle

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ack   <= 1'b0;
            r_count <= '0;
            r_cmp   <= '1;
            r_match <= 1'b0;
        end
        else
        begin
            o_ack   <= i_cs;
            r_count <= r_count + 1'b1;

            if (wr_en && r_addr == CmpWord)
            begin
                for (int i = 0; i < dbus_pkg::STRB_WIDTH; i++)
                begin
                    if (r_sel[i])
                        r_cmp[i*8 +: 8] <= r_wdata[i*8 +: 8];
                end
            end

            // a new match wins over a clear in the same cycle
            if (r_count == r_cmp)
                r_match <= 1'b1;
            else if (wr_en && r_addr == StatusWord && r_sel[0] && r_wdata[0])
                r_match <= 1'b0;
        end
    end

    always_comb
    begin
        case (r_addr)
            CountWord:  o_rdata = r_count;
            CmpWord:    o_rdata = r_cmp;
            StatusWord: o_rdata = {{(dbus_pkg::DATA_WIDTH-1){1'b0}}, r_match};
            default:    o_rdata = '0;
        endcase
    end

    assign o_irq = r_match;

endmodule

// ==== testbench/tb_dbus_top.sv ====
`timescale 1ns/1ps

module tb_dbus_top;

    localparam int TcmWords  = 2 ** dbus_pkg::TCM_ADDR_WIDTH;
    localparam int MaxCycles = 20000;  // ~1000 transactions of <= 12 cycles plus timer waits

    logic               clk;
    logic               rst_n;
    dbus_pkg::addr_t    awaddr;
    logic               awvalid;
    logic               awready;
    dbus_pkg::data_t    wdata;
    dbus_pkg::strb_t    wstrb;
    logic               wvalid;
    logic               wready;
    logic               bvalid;
    dbus_pkg::resp_t    bresp;
    logic               bready;
    dbus_pkg::addr_t    araddr;
    logic               arvalid;
    logic               arready;
    logic               rvalid;
    dbus_pkg::data_t    rdata;
    dbus_pkg::resp_t    rresp;
    logic               rready;
    logic               irq;
    logic [31:0]        lfsr = 32'h972a;
    int                 cycles = 0;
    dbus_pkg::data_t    shadow [TcmWords];  // expected TCM contents

    dbus_top dut0
    (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_awaddr  (awaddr),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_wdata   (wdata),
        .i_wstrb   (wstrb),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_bvalid  (bvalid),
        .o_bresp   (bresp),
        .i_bready  (bready),
        .i_araddr  (araddr),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_rvalid  (rvalid),
        .o_rdata   (rdata),
        .o_rresp   (rresp),
        .i_rready  (rready),
        .o_irq     (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        abort($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles)
            abort("timeout, the run went past its cycle limit");
    end

    // response must hold until taken, and nothing new is accepted meanwhile
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else abort("write response changed or dropped before bready");
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else abort("read response changed or dropped before rready");
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid || rvalid |-> !awready && !wready && !arready)
        else abort("a request channel was ready while a response was pending");

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic dbus_pkg::data_t merge(input dbus_pkg::data_t old_d,
                                              input dbus_pkg::data_t new_d,
                                              input dbus_pkg::strb_t s);
        dbus_pkg::data_t v;
        v = old_d;
        for (int i = 0; i < 4; i++)
        begin
            if (s[i])
                v[i*8 +: 8] = new_d[i*8 +: 8];
        end
        return v;
    endfunction

    function automatic dbus_pkg::addr_t tcm_addr(input int idx);
        return dbus_pkg::TCM_BASE + dbus_pkg::addr_t'(idx * 4);
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic axi_write(input dbus_pkg::addr_t a, input dbus_pkg::data_t d,
                             input dbus_pkg::strb_t s, input int order,
                             output dbus_pkg::resp_t resp);
        logic aw_done;
        logic w_done;
        logic aw_acc;
        logic w_acc;
        int   hold;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = (order != 1);  // 0 aw first, 1 w first, 2 together
        wvalid  = (order != 0);
        while (!(aw_done && w_done))
        begin
            @(negedge clk);
            aw_acc = awvalid && awready;
            w_acc  = wvalid && wready;
            step();
            if (aw_acc)
            begin
                aw_done = 1'b1;
                awvalid = 1'b0;
            end
            if (w_acc)
            begin
                w_done = 1'b1;
                wvalid = 1'b0;
            end
            wvalid  = wvalid || (aw_done && !w_done);
            awvalid = awvalid || (w_done && !aw_done);
        end
        hold = int'(rand_bits(2));
        while (!bvalid)
            step();
        repeat (hold)
            step();  // bready held low
        resp   = bresp;
        bready = 1'b1;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input dbus_pkg::addr_t a, output dbus_pkg::data_t d,
                            output dbus_pkg::resp_t resp);
        logic acc;
        int   hold;
        araddr  = a;
        arvalid = 1'b1;
        do
        begin
            @(negedge clk);
            acc = arready;
            step();
        end
        while (!acc);
        arvalid = 1'b0;
        hold    = int'(rand_bits(2));
        while (!rvalid)
            step();
        repeat (hold)
            step();
        d      = rdata;
        resp   = rresp;
        rready = 1'b1;
        step();
        rready = 1'b0;
    endtask

    task automatic check_write(input dbus_pkg::addr_t a, input dbus_pkg::data_t d,
                               input dbus_pkg::strb_t s, input int order,
                               input dbus_pkg::resp_t exp_r);
        dbus_pkg::resp_t r;
        axi_write(a, d, s, order, r);
        assert (r == exp_r) else fail_value("o_bresp", r, exp_r);
    endtask

    task automatic check_read(input dbus_pkg::addr_t a, input dbus_pkg::data_t exp_d,
                              input dbus_pkg::resp_t exp_r);
        dbus_pkg::data_t d;
        dbus_pkg::resp_t r;
        axi_read(a, d, r);
        assert (r == exp_r) else fail_value("o_rresp", r, exp_r);
        assert (d == exp_d) else fail_value("o_rdata", d, exp_d);
    endtask

    initial
    begin
        dbus_pkg::addr_t bad [3];
        dbus_pkg::addr_t cmp_a;
        dbus_pkg::addr_t sts_a;
        dbus_pkg::data_t d;
        dbus_pkg::data_t c1;
        dbus_pkg::data_t c2;
        dbus_pkg::data_t cmp_exp;
        dbus_pkg::strb_t s;
        dbus_pkg::resp_t r;
        int              idx;
        int              n;
        bad     = '{32'h0000_0800, 32'h0000_100c, 32'h0000_2000};
        cmp_a   = dbus_pkg::TIMER_BASE + dbus_pkg::TIMER_CMP_OFS;
        sts_a   = dbus_pkg::TIMER_BASE + dbus_pkg::TIMER_STATUS_OFS;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rst_n   = 1'b0;
        repeat (2)
            @(posedge clk);
        #2 rst_n = 1'b1;
        assert (!awready) else fail_value("o_awready", awready, 0);
        assert (!wready) else fail_value("o_wready", wready, 0);
        assert (!arready) else fail_value("o_arready", arready, 0);
        assert (!bvalid) else fail_value("o_bvalid", bvalid, 0);
        assert (!rvalid) else fail_value("o_rvalid", rvalid, 0);
        assert (!irq) else fail_value("o_irq", irq, 0);

        for (int i = 0; i < TcmWords; i++)
        begin
            shadow[i] = rand_bits(32);
            check_write(tcm_addr(i), shadow[i], 4'hf, i % 3, dbus_pkg::RESP_OKAY);
        end
        for (int i = 0; i < TcmWords; i++)
            check_read(tcm_addr(i), shadow[i], dbus_pkg::RESP_OKAY);

        for (int k = 0; k < 100; k++)
        begin
            idx = int'(rand_bits(8));
            d   = rand_bits(32);
            s   = (k == 0) ? 4'h0 : dbus_pkg::strb_t'(rand_bits(4));
            shadow[idx] = merge(shadow[idx], d, s);
            check_write(tcm_addr(idx), d, s, int'(rand_bits(2)) % 3, dbus_pkg::RESP_OKAY);
            check_read(tcm_addr(idx), shadow[idx], dbus_pkg::RESP_OKAY);
        end

        for (int k = 0; k < 3; k++)
        begin
            check_read(bad[k], '0, dbus_pkg::RESP_DECERR);
            check_write(bad[k], rand_bits(32), 4'hf, k, dbus_pkg::RESP_DECERR);
        end
        for (int i = 0; i < TcmWords; i++)
            check_read(tcm_addr(i), shadow[i], dbus_pkg::RESP_OKAY);

        // top byte kept at ff so the compare stays far from the counter
        d       = rand_bits(32);
        s       = dbus_pkg::strb_t'(rand_bits(3));
        cmp_exp = merge('1, d, s);
        check_write(cmp_a, d, s, 2, dbus_pkg::RESP_OKAY);
        check_read(cmp_a, cmp_exp, dbus_pkg::RESP_OKAY);

        axi_read(dbus_pkg::TIMER_BASE + dbus_pkg::TIMER_COUNT_OFS, c1, r);
        axi_read(dbus_pkg::TIMER_BASE + dbus_pkg::TIMER_COUNT_OFS, c2, r);
        assert (c2 > c1)
            else abort($sformatf("FAIL o_rdata timer count 0x%08h then 0x%08h", c1, c2));
        check_write(cmp_a, c1 + 200, 4'hf, 0, dbus_pkg::RESP_OKAY);
        check_read(cmp_a, c1 + 200, dbus_pkg::RESP_OKAY);
        n = 0;
        while (!irq && n < 300)
        begin
            step();
            n++;
        end
        assert (irq) else abort("o_irq did not rise within 300 cycles of the compare write");
        check_read(sts_a, 32'h1, dbus_pkg::RESP_OKAY);
        check_write(sts_a, 32'h1, 4'h1, 1, dbus_pkg::RESP_OKAY);
        assert (!irq) else fail_value("o_irq", irq, 0);
        check_read(sts_a, 32'h0, dbus_pkg::RESP_OKAY);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
